// File: Makefile
VERILATOR ?= verilator
TOP       ?= mipsCore_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv testbench/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)

// File: design/alu.sv
//==================================================
// ALU
// resolves the operation from class and function,
// selects the second operand and computes the
// result with its zero flag
//==================================================
`default_nettype none

`include "mipsParams_params.svh"

module alu
  import mipsPkg::*;
(
  input  aluClassT                aluClass,
  input  logic [5:0]              funct,
  input  logic [15:0]             immediate,
  input  logic                    aluSrc,
  input  logic [`DATA_WIDTH-1:0]  operandA,
  input  logic [`DATA_WIDTH-1:0]  operandB,
  output logic [`DATA_WIDTH-1:0]  result,
  output logic                    zero
);

  aluOpT                   aluOp;
  logic [`DATA_WIDTH-1:0]  immExt;
  logic [`DATA_WIDTH-1:0]  srcB;

  // sign-extended immediate for lw and sw offsets
  assign immExt = {{(`DATA_WIDTH-16){immediate[15]}}, immediate};
  assign srcB   = aluSrc ? immExt : operandB;

  //==================================================
  // operation select
  always_comb begin
    case (aluClass)
      clsMemAddr:   aluOp = opAdd;
      clsBranchCmp: aluOp = opSub;
      clsRType: begin
        case (funct)
          `FN_ADD: aluOp = opAdd;
          `FN_SUB: aluOp = opSub;
          `FN_AND: aluOp = opAnd;
          `FN_OR:  aluOp = opOr;
          `FN_SLT: aluOp = opSlt;
          default: aluOp = opNone;
        endcase
      end
      default: aluOp = opNone;
    endcase
  end

  //==================================================
  // arithmetic
  always_comb begin
    case (aluOp)
      opAdd: result = operandA + srcB;
      opSub: result = operandA - srcB;
      opAnd: result = operandA & srcB;
      opOr:  result = operandA | srcB;
      // signed compare, so negative values order correctly
      opSlt: result = {{(`DATA_WIDTH-1){1'b0}}, ($signed(operandA) < $signed(srcB))};
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/mainDecoder.sv
//==================================================
// Main decoder
// maps the opcode onto the datapath control levels
// for one single-cycle instruction
//==================================================
`default_nettype none

`include "mipsParams_params.svh"

module mainDecoder
  import mipsPkg::*;
(
  input  logic [5:0] opcode,
  output logic       regDst,
  output logic       aluSrc,
  output logic       memToReg,
  output logic       regWrite,
  output logic       memWrite,
  output logic       branch,
  output logic       jump,
  output logic       link,
  output aluClassT   aluClass
);

  always_comb begin
    // safe defaults: nothing written, no redirect
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    aluClass = clsMemAddr;
    case (opcode)
      `OP_RTYPE: begin
        // rd <= rs op rt
        regDst   = 1'b1;
        regWrite = 1'b1;
        aluClass = clsRType;
      end
      `OP_LW: begin
        // rt <= mem[rs + imm]
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      `OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      `OP_BEQ: begin
        // zero flag from rs - rt decides
        branch   = 1'b1;
        aluClass = clsBranchCmp;
      end
      `OP_J: jump = 1'b1;
      `OP_JAL: begin
        // return address goes to the link register
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/mipsCore.sv
//==================================================
// Single-cycle MIPS core
// decoder, PC, register file and ALU wired to the
// instruction memory and the data SRAM ports
//==================================================
`default_nettype none

`include "mipsParams_params.svh"

module mipsCore
  import mipsPkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic [`DATA_WIDTH-1:0]      ir,
  input  logic [`DATA_WIDTH-1:0]      readDataMem,
  output logic [`DATA_WIDTH-1:0]      irAddr,
  output logic [`DATA_WIDTH-1:0]      rfWriteData,
  output logic [`DATA_WIDTH-1:0]      writeDataMem,
  output logic [`DMEM_ADDR_WIDTH-1:0] dataAddr,
  output logic                        wen
);

  // control levels
  logic     regDst, aluSrc, memToReg, regWrite;
  logic     memWrite, branch, jump, link;
  aluClassT aluClass;

  // datapath
  logic [`DATA_WIDTH-1:0] rsData, rtData;
  logic [`DATA_WIDTH-1:0] aluResult, linkAddr;
  logic                   zero;

  //==================================================
  // blocks, ir fields sliced at the ports
  mainDecoder decoder (
    .opcode(ir[31:26]), .regDst(regDst), .aluSrc(aluSrc),
    .memToReg(memToReg), .regWrite(regWrite), .memWrite(memWrite),
    .branch(branch), .jump(jump), .link(link), .aluClass(aluClass)
  );

  programCounter pcUnit (
    .clk(clk), .rst(rst), .branch(branch), .jump(jump), .zero(zero),
    .immediate(ir[15:0]), .target(ir[25:0]), .pc(irAddr), .linkAddr(linkAddr)
  );

  registerFile regFile (
    .clk(clk), .rst(rst), .regWrite(regWrite), .regDst(regDst),
    .memToReg(memToReg), .link(link),
    .rsIdx(ir[25:21]), .rtIdx(ir[20:16]), .rdIdx(ir[15:11]),
    .aluResult(aluResult), .memData(readDataMem), .linkAddr(linkAddr),
    .rsData(rsData), .rtData(rtData), .writeData(rfWriteData)
  );

  alu aluUnit (
    .aluClass(aluClass), .funct(ir[5:0]), .immediate(ir[15:0]), .aluSrc(aluSrc),
    .operandA(rsData), .operandB(rtData), .result(aluResult), .zero(zero)
  );

  //==================================================
  // SRAM port, byte address turned into word address
  assign dataAddr     = aluResult[`DMEM_ADDR_WIDTH+1:2];
  assign writeDataMem = rtData;
  // active-low write strobe, low only for sw
  assign wen          = ~memWrite;

endmodule

`default_nettype wire

// File: design/mipsPkg.sv
//==================================================
// MIPS core types
// ALU operation and ALU operation class encodings
//==================================================
`default_nettype none

package mipsPkg;

  // operation the ALU actually performs
  typedef enum logic [2:0] {
    opAdd  = 3'd0,
    opSub  = 3'd1,
    opAnd  = 3'd2,
    opOr   = 3'd3,
    opSlt  = 3'd4,
    // unknown function field, result forced to zero
    opNone = 3'd7
  } aluOpT;

  // how the operation gets picked
  typedef enum logic [1:0] {
    // lw and sw address calculation
    clsMemAddr   = 2'd0,
    // beq compare through subtraction
    clsBranchCmp = 2'd1,
    // taken from the function field
    clsRType     = 2'd2
  } aluClassT;

endpackage

`default_nettype wire

// File: design/programCounter.sv
//==================================================
// Program counter
// PC register with sequential, branch and jump
// next-address selection and the jal link address
//==================================================
`default_nettype none

`include "mipsParams_params.svh"

module programCounter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    branch,
  input  logic                    jump,
  input  logic                    zero,
  input  logic [15:0]             immediate,
  input  logic [25:0]             target,
  output logic [`DATA_WIDTH-1:0]  pc,
  output logic [`DATA_WIDTH-1:0]  linkAddr
);

  logic [`DATA_WIDTH-1:0] pcPlus4;
  logic [`DATA_WIDTH-1:0] branchOffset;
  logic [`DATA_WIDTH-1:0] pcNext;

  assign pcPlus4  = pc + `DATA_WIDTH'd4;
  // jal return address, skips the delay slot
  assign linkAddr = pc + `DATA_WIDTH'd8;

  // word offset, sign-extended then shifted by 2
  assign branchOffset = {{(`DATA_WIDTH-18){immediate[15]}}, immediate, 2'b00};

  // jump wins over a taken branch
  always_comb begin
    if (jump)
      pcNext = {pcPlus4[31:28], target, 2'b00};
    else if (branch && zero)
      pcNext = pcPlus4 + branchOffset;
    else
      pcNext = pcPlus4;
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst)
      pc <= '0;
    else
      pc <= pcNext;
  end

endmodule

`default_nettype wire

// File: design/registerFile.sv
//==================================================
// Register file
// 32 x 32 registers, two combinational reads, one
// write per cycle, with destination and write-back
// source selection
//==================================================
`default_nettype none

`include "mipsParams_params.svh"

module registerFile (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       regWrite,
  input  logic                       regDst,
  input  logic                       memToReg,
  input  logic                       link,
  input  logic [`REG_ADDR_WIDTH-1:0] rsIdx,
  input  logic [`REG_ADDR_WIDTH-1:0] rtIdx,
  input  logic [`REG_ADDR_WIDTH-1:0] rdIdx,
  input  logic [`DATA_WIDTH-1:0]     aluResult,
  input  logic [`DATA_WIDTH-1:0]     memData,
  input  logic [`DATA_WIDTH-1:0]     linkAddr,
  output logic [`DATA_WIDTH-1:0]     rsData,
  output logic [`DATA_WIDTH-1:0]     rtData,
  output logic [`DATA_WIDTH-1:0]     writeData
);

  logic [`DATA_WIDTH-1:0]     regs [`REG_COUNT];
  logic [`REG_ADDR_WIDTH-1:0] destIdx;

  // jal targets the link register, R-type uses rd, lw uses rt
  assign destIdx = link   ? `REG_ADDR_WIDTH'(`LINK_REG) :
                   regDst ? rdIdx : rtIdx;

  // write-back source
  assign writeData = link     ? linkAddr :
                     memToReg ? memData  : aluResult;

  //==================================================
  // storage, $zero never written
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end else if (regWrite && (destIdx != '0)) begin
      regs[destIdx] <= writeData;
    end
  end

  // reads are combinational, register 0 hardwired to zero
  assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
  assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

endmodule

`default_nettype wire

// File: include/mipsParams_params.svh
//==================================================
// MIPS core parameters
// word width, register file sizing, SRAM address
// width and the opcode and function encodings
//==================================================
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath sizing
`define DATA_WIDTH       32
`define REG_ADDR_WIDTH   5
`define REG_COUNT        (1 << `REG_ADDR_WIDTH)
`define LINK_REG         31
// SRAM word address, 128 words
`define DMEM_ADDR_WIDTH  7

// opcodes, ir[31:26]
`define OP_RTYPE  6'b000000
`define OP_LW     6'b100011
`define OP_SW     6'b101011
`define OP_BEQ    6'b000100
`define OP_J      6'b000010
`define OP_JAL    6'b000011

// R-type function field, ir[5:0]
`define FN_ADD    6'b100000
`define FN_SUB    6'b100010
`define FN_AND    6'b100100
`define FN_OR     6'b100101
`define FN_SLT    6'b101010

`endif

// File: testbench/mipsCore_properties.sv
//==================================================
// MIPS core port properties
// PC alignment, write strobe after reset and SRAM
// store signals held steady through the cycle
//==================================================
`default_nettype none

`include "mipsParams_params.svh"

module mipsCoreProperties (
  input logic                        clk,
  input logic                        rst,
  input logic [`DATA_WIDTH-1:0]      irAddr,
  input logic [`DATA_WIDTH-1:0]      writeDataMem,
  input logic [`DMEM_ADDR_WIDTH-1:0] dataAddr,
  input logic                        wen
);

  // mid-cycle copies of the store port
  logic [`DMEM_ADDR_WIDTH-1:0] midAddr;
  logic [`DATA_WIDTH-1:0]      midData;

  always @(negedge clk) begin
    midAddr <= dataAddr;
    midData <= writeDataMem;
  end

  // instruction fetch stays on word boundaries
  pcAligned: assert property (@(posedge clk) disable iff (!rst) irAddr[1:0] == 2'b00)
    else $error("irAddr is not word aligned");

  // first instruction after reset writes nothing
  wenAfterReset: assert property (@(posedge clk) $rose(rst) |-> wen)
    else $error("wen is low in the first cycle after reset");

  // sw address and data unchanged from mid-cycle to the edge
  storeStable: assert property (@(posedge clk) disable iff (!rst)
    !wen |-> (dataAddr == midAddr && writeDataMem == midData))
    else $error("dataAddr or writeDataMem changed during a store cycle");

endmodule

`default_nettype wire

// File: testbench/mipsCore_tb.sv
//==================================================
// MIPS core testbench
// instruction and data memory models, a reference
// model of the instruction set and per-cycle checks
//==================================================
`default_nettype none

`include "mipsParams_params.svh"

module mipsCore_tb;

  localparam int RESET_CYCLES = 10;
  localparam int PROG_LEN     = 23;
  localparam int CYCLE_LIMIT  = 4 * PROG_LEN + RESET_CYCLES;
  localparam int DMEM_WORDS   = 1 << `DMEM_ADDR_WIDTH;

  logic                        clk = 1'b0;
  logic                        rst;
  logic [`DATA_WIDTH-1:0]      ir, readDataMem, irAddr, rfWriteData, writeDataMem;
  logic [`DMEM_ADDR_WIDTH-1:0] dataAddr;
  logic                        wen;

  // memory models
  logic [31:0] prog [64] = '{default: 32'd0};
  logic [31:0] dmem [DMEM_WORDS];

  // reference model state
  logic [31:0] mRegs [`REG_COUNT] = '{default: 32'd0};
  logic [31:0] mMem [DMEM_WORDS];
  logic [31:0] mPc = 32'd0;

  // per-cycle predictions
  logic [31:0] expWb, expWriteData, expNextPc;
  logic [6:0]  expAddr;
  logic [4:0]  wrIdx;
  logic        expWen, cmpWb, cmpAddr;
  logic        running = 1'b0;
  logic        resetChecked = 1'b0;

  int    curSection;
  int    errorCount = 0;
  int    passedCount = 0;
  int    failedCount = 0;
  int    cycles = 0;
  int    sectionErrors [6] = '{default: 0};
  // first instruction index past each section
  int    sectionEnd [6] = '{1, 9, 11, 15, 20, 22};
  string sectionName [6] = '{"reset", "arithmetic", "memory", "branches", "jumps", "register 0"};

  always #50 clk = ~clk;

  mipsCore uut (
    .clk(clk), .rst(rst), .ir(ir), .readDataMem(readDataMem), .irAddr(irAddr),
    .rfWriteData(rfWriteData), .writeDataMem(writeDataMem), .dataAddr(dataAddr), .wen(wen)
  );

  bind mipsCore mipsCoreProperties props (
    .clk(clk), .rst(rst), .irAddr(irAddr), .writeDataMem(writeDataMem),
    .dataAddr(dataAddr), .wen(wen)
  );

  // instruction memory and SRAM, both read combinationally
  assign ir          = prog[irAddr[7:2]];
  assign readDataMem = dmem[dataAddr];

  always @(posedge clk) begin
    if (rst && !wen)
      dmem[dataAddr] <= writeDataMem;
  end

  //==================================================
  // helpers
  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
    return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic logMismatch(input int sec, input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    errorCount++;
    sectionErrors[sec]++;
    $display("ERROR at time %0t: %s expected %h, actual %h", $time, name, expected, actual);
  endtask

  task automatic printSection(input int sec);
    if (sectionErrors[sec] == 0) begin
      passedCount++;
      $display("section %s: passed", sectionName[sec]);
    end else begin
      failedCount++;
      $display("section %s: failed with %0d errors", sectionName[sec], sectionErrors[sec]);
    end
  endtask

  task automatic loadProgram();
    // two random words, then every R-type operation
    prog[0]  = encodeI(`OP_LW, 5'd0, 5'd1, 16'd0);
    prog[1]  = encodeI(`OP_LW, 5'd0, 5'd2, 16'd4);
    prog[2]  = encodeR(5'd0, 5'd1, 5'd3, `FN_SUB);
    prog[3]  = encodeR(5'd1, 5'd2, 5'd4, `FN_ADD);
    prog[4]  = encodeR(5'd1, 5'd2, 5'd5, `FN_SUB);
    prog[5]  = encodeR(5'd1, 5'd2, 5'd6, `FN_AND);
    prog[6]  = encodeR(5'd1, 5'd2, 5'd7, `FN_OR);
    prog[7]  = encodeR(5'd1, 5'd2, 5'd8, `FN_SLT);
    // $3 is -$1, so one operand is negative
    prog[8]  = encodeR(5'd3, 5'd1, 5'd9, `FN_SLT);
    // store then reload word 16
    prog[9]  = encodeI(`OP_SW, 5'd0, 5'd4, 16'd64);
    prog[10] = encodeI(`OP_LW, 5'd0, 5'd10, 16'd64);
    // not taken, forward to 14, back to 13, out to 15
    prog[11] = encodeI(`OP_BEQ, 5'd2, 5'd0, 16'd1);
    prog[12] = encodeI(`OP_BEQ, 5'd10, 5'd4, 16'd1);
    prog[13] = encodeI(`OP_BEQ, 5'd0, 5'd0, 16'd1);
    prog[14] = encodeI(`OP_BEQ, 5'd0, 5'd0, 16'hfffe);
    // j and jal each skip one slot
    prog[15] = encodeJ(`OP_J, 26'd17);
    prog[17] = encodeJ(`OP_JAL, 26'd19);
    prog[19] = encodeR(5'd31, 5'd0, 5'd13, `FN_ADD);
    // write $0, then read it back
    prog[20] = encodeR(5'd1, 5'd2, 5'd0, `FN_ADD);
    prog[21] = encodeR(5'd0, 5'd0, 5'd14, `FN_OR);
    // park
    prog[22] = encodeJ(`OP_J, 26'd22);
  endtask

  //==================================================
  // reference model
  task automatic predictCycle();
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] addr;
    logic [31:0] pc4;
    instr = prog[mPc[7:2]];
    a = mRegs[instr[25:21]];
    b = mRegs[instr[20:16]];
    sext = {{16{instr[15]}}, instr[15:0]};
    addr = a + sext;
    pc4 = mPc + 32'd4;
    expNextPc = pc4;
    expWriteData = b;
    expWen = 1'b1;
    expWb = 32'd0;
    expAddr = addr[8:2];
    wrIdx = 5'd0;
    cmpWb = 1'b0;
    cmpAddr = 1'b0;
    case (instr[31:26])
      `OP_RTYPE: begin
        case (instr[5:0])
          `FN_ADD: expWb = a + b;
          `FN_SUB: expWb = a - b;
          `FN_AND: expWb = a & b;
          `FN_OR:  expWb = a | b;
          `FN_SLT: expWb = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: expWb = 32'd0;
        endcase
        cmpWb = 1'b1;
        wrIdx = instr[15:11];
      end
      `OP_LW: begin
        expWb = mMem[addr[8:2]];
        cmpWb = 1'b1;
        cmpAddr = 1'b1;
        wrIdx = instr[20:16];
      end
      `OP_SW: begin
        expWen = 1'b0;
        cmpAddr = 1'b1;
      end
      `OP_BEQ: begin
        if (a == b)
          expNextPc = pc4 + {sext[29:0], 2'b00};
      end
      `OP_J: expNextPc = {pc4[31:28], instr[25:0], 2'b00};
      `OP_JAL: begin
        expNextPc = {pc4[31:28], instr[25:0], 2'b00};
        expWb = mPc + 32'd8;
        cmpWb = 1'b1;
        wrIdx = 5'd31;
      end
      default: ;
    endcase
    // section owning this instruction
    curSection = 5;
    for (int s = 5; s >= 1; s--) begin
      if (int'(mPc[31:2]) < sectionEnd[s])
        curSection = s;
    end
  endtask

  task automatic retireCycle();
    if (cmpWb && wrIdx != 5'd0)
      mRegs[wrIdx] = expWb;
    if (!expWen)
      mMem[expAddr] = expWriteData;
    mPc = expNextPc;
  endtask

  //==================================================
  // checks at the falling edge, outputs settled
  always @(negedge clk) begin
    if (running) begin
      if (!resetChecked) begin
        assert (irAddr == 32'd0) else logMismatch(0, "irAddr", 32'd0, irAddr);
        assert (wen) else logMismatch(0, "wen", 32'd1, 32'(wen));
        resetChecked = 1'b1;
      end
      predictCycle();
      assert (irAddr == mPc) else logMismatch(curSection, "irAddr", mPc, irAddr);
      assert (wen == expWen) else logMismatch(curSection, "wen", 32'(expWen), 32'(wen));
      assert (writeDataMem == expWriteData)
        else logMismatch(curSection, "writeDataMem", expWriteData, writeDataMem);
      if (cmpAddr) begin
        assert (dataAddr == expAddr)
          else logMismatch(curSection, "dataAddr", 32'(expAddr), 32'(dataAddr));
      end
      if (cmpWb) begin
        assert (rfWriteData == expWb)
          else logMismatch(curSection, "rfWriteData", expWb, rfWriteData);
      end
      retireCycle();
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the program did not reach its end within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  //==================================================
  // stimulus and report
  initial begin
    logic [31:0] lcgState;
    rst = 1'b0;
    loadProgram();
    // same random words in the SRAM and the model
    lcgState = 32'haed738f1;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      lcgState = lcgNext(lcgState);
      dmem[i] = lcgState;
      mMem[i] = lcgState;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b1;
    running <= 1'b1;
    wait (resetChecked);
    printSection(0);
    for (int s = 1; s < 6; s++) begin
      while (irAddr != 32'(sectionEnd[s] * 4))
        @(negedge clk);
      printSection(s);
    end
    @(posedge clk);
    $display("%0d sections passed, %0d failed, %0d errors in total",
             passedCount, failedCount, errorCount);
    if (errorCount == 0 && failedCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
design/mipsPkg.sv
design/mainDecoder.sv
design/alu.sv
design/programCounter.sv
design/registerFile.sv
design/mipsCore.sv
testbench/mipsCore_properties.sv
testbench/mipsCore_tb.sv
